// File: common/cpu_defines.svh
// core width and reset constants
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and instruction widths
`define XLEN 64                  // rv64 integer word
`define ILEN 32                  // base encoding, no compressed

// architectural register count
`define NUM_REGS 32              // x0..x31, x0 hardwired zero

// fetch address after reset
`define RESET_PC 64'h0

// addi x0, x0, 0
// held in the instruction latch while the packet is invalid
`define NOP_INSTR 32'h0000_0013

`endif

// File: common/cpu_pkg.sv
// core types and pipeline structs
`default_nettype none
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0] xlen_t;                  // data word
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;   // register index

    // major opcodes of the kept instructions
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // one struct per format, fields at their isa bit positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;      // upper 20 bits
        reg_idx_t    rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    // decoded control, all zero means no-op
    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;         // sign extended
        alu_op_e  alu_op;
        logic     use_imm;     // operand b from imm
        logic     use_pc;      // operand a from pc, auipc
        logic     reg_we;
        logic     mem_load;
        logic     mem_store;
        branch_e  branch;
        logic     jal;
        logic     jalr;
    } decoded_t;

    typedef struct packed {
        instr_u instr;
        xlen_t  pc;
        logic   valid;         // low for reset and flushed slots
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t addr;
        xlen_t wdata;
        logic  we;             // one cycle write strobe
    } dmem_req_t;

endpackage

`default_nettype wire

// File: execute/decoder.sv
// instruction decoder
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  wire cpu_pkg::instr_u instr,
    output cpu_pkg::decoded_t    dec
);
    import cpu_pkg::*;

    decoded_t d;               // raw decode before the support check
    logic     supported;
    xlen_t    imm_i;
    xlen_t    imm_s;
    xlen_t    imm_b;
    xlen_t    imm_u;
    xlen_t    imm_j;

    // funct3 to alu op, shared by op-imm and op
    function automatic alu_op_e f3_alu(input logic [2:0] f3);
        case (f3)
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic branch_e f3_branch(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;     // 010, 011 reserved
        endcase
    endfunction

    // immediates, each from its own format view
    assign imm_i = {{52{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{52{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
    assign imm_b = {{51{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {{32{instr.u.imm[19]}}, instr.u.imm, 12'b0};
    assign imm_j = {{43{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        d         = '0;
        supported = 1'b0;
        case (instr.r.opcode)
            OP_LUI: begin
                supported = 1'b1;
                d.rd      = instr.u.rd;
                d.imm     = imm_u;
                d.alu_op  = ALU_PASS_B;
                d.use_imm = 1'b1;
                d.reg_we  = 1'b1;
            end
            OP_AUIPC: begin
                supported = 1'b1;
                d.rd      = instr.u.rd;
                d.imm     = imm_u;
                d.use_pc  = 1'b1;          // pc + imm
                d.use_imm = 1'b1;
                d.reg_we  = 1'b1;
            end
            OP_JAL: begin
                supported = 1'b1;
                d.rd      = instr.j.rd;
                d.imm     = imm_j;
                d.reg_we  = 1'b1;          // link pc+4
                d.jal     = 1'b1;
            end
            OP_JALR: begin
                supported = (instr.i.funct3 == 3'b000);
                d.rd      = instr.i.rd;
                d.rs1     = instr.i.rs1;
                d.imm     = imm_i;
                d.use_imm = 1'b1;          // alu forms rs1 + imm
                d.reg_we  = 1'b1;
                d.jalr    = 1'b1;
            end
            OP_BRANCH: begin
                d.branch  = f3_branch(instr.b.funct3);
                supported = (d.branch != BR_NONE);
                d.rs1     = instr.b.rs1;
                d.rs2     = instr.b.rs2;
                d.imm     = imm_b;
            end
            OP_LOAD: begin
                supported  = (instr.i.funct3 == 3'b011);    // ld only
                d.rd       = instr.i.rd;
                d.rs1      = instr.i.rs1;
                d.imm      = imm_i;
                d.use_imm  = 1'b1;
                d.reg_we   = 1'b1;
                d.mem_load = 1'b1;
            end
            OP_STORE: begin
                supported   = (instr.s.funct3 == 3'b011);   // sd only
                d.rs1       = instr.s.rs1;
                d.rs2       = instr.s.rs2;
                d.imm       = imm_s;
                d.use_imm   = 1'b1;
                d.mem_store = 1'b1;
            end
            OP_IMM: begin
                supported = (instr.i.funct3[1:0] != 2'b01); // no shifts
                d.rd      = instr.i.rd;
                d.rs1     = instr.i.rs1;
                d.imm     = imm_i;
                d.alu_op  = f3_alu(instr.i.funct3);
                d.use_imm = 1'b1;
                d.reg_we  = 1'b1;
            end
            OP_REG: begin
                supported = (instr.r.funct7 == 7'b0000000 && instr.r.funct3[1:0] != 2'b01)
                         || (instr.r.funct7 == 7'b0100000 && instr.r.funct3 == 3'b000);
                d.rd      = instr.r.rd;
                d.rs1     = instr.r.rs1;
                d.rs2     = instr.r.rs2;
                d.alu_op  = instr.r.funct7[5] ? ALU_SUB : f3_alu(instr.r.funct3);
                d.reg_we  = 1'b1;
            end
            default: supported = 1'b0;    // system, fence, w ops and the rest
        endcase
    end

    assign dec = supported ? d : '0;   // unsupported runs as a no-op

endmodule

`default_nettype wire

// File: execute/alu.sv
// integer alu and branch compare
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_pkg::xlen_t   op_a,
    input  wire cpu_pkg::xlen_t   op_b,
    input  wire cpu_pkg::alu_op_e alu_op,
    input  wire cpu_pkg::branch_e branch,
    output cpu_pkg::xlen_t        result,
    output logic                  taken     // branch condition holds
);
    import cpu_pkg::*;

    logic lt_s;                // signed a < b
    logic lt_u;                // unsigned a < b
    logic eq;

    // one comparator pair feeds slt and the branches
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;
    assign eq   = (op_a == op_b);

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLT:    result = xlen_t'(lt_s);
            ALU_SLTU:   result = xlen_t'(lt_u);
            ALU_XOR:    result = op_a ^ op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;          // lui
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (branch)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt_s;
            BR_GE:   taken = !lt_s;
            BR_LTU:  taken = lt_u;
            BR_GEU:  taken = !lt_u;
            default: taken = 1'b0;              // not a branch
        endcase
    end

endmodule

`default_nettype wire

// File: execute/reg_file.sv
// integer register file
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defines.svh"

module reg_file (
    input  wire                   clk_1hz,
    input  wire                   reset_n,
    input  wire cpu_pkg::reg_idx_t rs1,
    input  wire cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::xlen_t        rs1_data,
    output cpu_pkg::xlen_t        rs2_data,
    input  wire                   we,
    input  wire cpu_pkg::reg_idx_t rd,
    input  wire cpu_pkg::xlen_t   rd_data
);
    import cpu_pkg::*;

    xlen_t regs [`NUM_REGS];

    // write at the end of the execute cycle
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin    // x0 never written
            regs[rd] <= rd_data;
        end
    end

    // combinational reads, same cycle as decode
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 stays zero through reset and every write
    x0_zero_a: assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0)
    ) else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: execute/execute_unit.sv
// execute stage with write-back and redirect
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  wire                     clk_1hz,
    input  wire                     reset_n,
    input  wire cpu_pkg::fetch_pkt_t fetch_pkt,
    output logic                    redirect,      // taken branch or jump
    output cpu_pkg::xlen_t          redirect_pc,
    output cpu_pkg::dmem_req_t      dmem_req,
    input  wire cpu_pkg::xlen_t     dmem_rdata     // same cycle load data
);
    import cpu_pkg::*;

    decoded_t dec;
    logic     valid;
    logic     taken;
    logic     link;            // jal or jalr
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    alu_result;
    xlen_t    pc_plus4;
    xlen_t    br_target;
    xlen_t    wb_data;

    assign valid = fetch_pkt.valid;    // gates every side effect

    decoder u_decoder (
        .instr (fetch_pkt.instr),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk_1hz  (clk_1hz),
        .reset_n  (reset_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (valid && dec.reg_we),
        .rd       (dec.rd),
        .rd_data  (wb_data)
    );

    // operand select
    assign op_a = dec.use_pc ? fetch_pkt.pc : rs1_data;     // auipc uses pc
    assign op_b = dec.use_imm ? dec.imm : rs2_data;

    alu u_alu (
        .op_a   (op_a),
        .op_b   (op_b),
        .alu_op (dec.alu_op),
        .branch (dec.branch),
        .result (alu_result),
        .taken  (taken)
    );

    assign link      = dec.jal || dec.jalr;
    assign pc_plus4  = fetch_pkt.pc + xlen_t'(4);
    assign br_target = fetch_pkt.pc + dec.imm;              // branches and jal

    // write-back mux
    assign wb_data = link ? pc_plus4 : (dec.mem_load ? dmem_rdata : alu_result);

    // alu sum rs1 + imm is the ld/sd address
    assign dmem_req = '{
        addr:  alu_result,
        wdata: rs2_data,
        we:    valid && dec.mem_store
    };

    // pc redirect, jalr drops bit zero
    assign redirect    = valid && (taken || link);
    assign redirect_pc = dec.jalr ? (alu_result & ~xlen_t'(1)) : br_target;

    // slot behind a redirect is flushed, so it must not reach memory
    flush_no_store_a: assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        redirect |=> !fetch_pkt.valid && !dmem_req.we
    ) else $error("store issued from flushed slot");

endmodule

`default_nettype wire

// File: fetch/fetch_stage.sv
// instruction fetch stage
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defines.svh"

module fetch_stage (
    input  wire                  clk_1hz,
    input  wire                  reset_n,
    input  wire                  redirect,     // from execute, one cycle
    input  wire cpu_pkg::xlen_t  redirect_pc,
    output cpu_pkg::xlen_t       imem_addr,
    input  wire cpu_pkg::instr_u imem_data,
    output cpu_pkg::fetch_pkt_t  fetch_pkt
);
    import cpu_pkg::*;

    xlen_t pc;

    assign imem_addr = pc;     // memory answers in the same cycle

    // pc register and instruction latch
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc              <= `RESET_PC;
            fetch_pkt.instr <= `NOP_INSTR;
            fetch_pkt.pc    <= `RESET_PC;
            fetch_pkt.valid <= 1'b0;
        end else begin
            // word at pc goes to execute next cycle
            fetch_pkt.instr <= imem_data;
            fetch_pkt.pc    <= pc;
            if (redirect) begin
                pc              <= redirect_pc;
                fetch_pkt.valid <= 1'b0;     // kill the word fetched behind the branch
            end else begin
                pc              <= pc + xlen_t'(4);
                fetch_pkt.valid <= 1'b1;
            end
        end
    end

    // targets from execute must keep word alignment
    pc_aligned_a: assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        pc[1:0] == 2'b00
    ) else $error("fetch pc misaligned: %h", pc);

endmodule

`default_nettype wire

// File: source/cpu_core.sv
// two stage rv64 core top
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
    input  wire                  clk_1hz,
    input  wire                  reset_n,
    // instruction port, asynchronous read
    output cpu_pkg::xlen_t       imem_addr,
    input  wire cpu_pkg::instr_u imem_data,
    // data port, asynchronous read, write at next edge
    output cpu_pkg::dmem_req_t   dmem_req,
    input  wire cpu_pkg::xlen_t  dmem_rdata
);
    import cpu_pkg::*;

    fetch_pkt_t fetch_pkt;     // fetch to execute
    logic       redirect;      // taken branch or jump
    xlen_t      redirect_pc;

    fetch_stage u_fetch (
        .clk_1hz     (clk_1hz),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fetch_pkt   (fetch_pkt)
    );

    // decode, register read, alu, memory and write-back in one cycle
    execute_unit u_execute (
        .clk_1hz     (clk_1hz),
        .reset_n     (reset_n),
        .fetch_pkt   (fetch_pkt),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .dmem_req    (dmem_req),
        .dmem_rdata  (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: tb/isa_model.svh
// in-order reference interpreter
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// one fetch slot as the core should present it
typedef struct packed {
    xlen_t addr;               // expected imem_addr
    logic  is_load;            // executes as ld in the next cycle
    xlen_t ld_data;            // expected dmem_rdata then
} fetch_exp_t;

fetch_exp_t exp_fetch [$];     // every fetch incl. flushed slots
dmem_req_t  exp_stores [$];    // sd stream in program order

function automatic xlen_t alu_ref(input logic [2:0] f3, input logic sub,
                                  input xlen_t a, input xlen_t b);
    case (f3)
        3'b010:  return {63'b0, $signed(a) < $signed(b)};
        3'b011:  return {63'b0, a < b};
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return sub ? a - b : a + b;
    endcase
endfunction

function automatic logic cond_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;               // bgeu
    endcase
endfunction

// walk the program until the closing self jump
task automatic interpret_program();
    xlen_t       x [`NUM_REGS];
    xlen_t       pc;
    xlen_t       next;
    xlen_t       res;
    xlen_t       addr;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_b;
    xlen_t       imm_u;
    xlen_t       imm_j;
    logic [31:0] w;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        wr;
    fetch_exp_t  slot;
    dmem_req_t   st;
    for (int r = 0; r < `NUM_REGS; r++) begin
        x[5'(r)] = '0;
    end
    pc = '0;
    while (pc != HALT_PC) begin
        w     = imem[pc[9:2]];
        rs1   = w[19:15];
        rs2   = w[24:20];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {{32{w[31]}}, w[31:12], 12'b0};
        imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        next  = pc + 64'd4;
        res   = '0;
        wr    = 1'b0;
        slot  = '0;
        slot.addr = pc;
        case (w[6:0])
            7'b0110111: begin res = imm_u; wr = 1'b1; end               // lui
            7'b0010111: begin res = pc + imm_u; wr = 1'b1; end          // auipc
            7'b1101111: begin
                res  = pc + 64'd4;                                      // link
                wr   = 1'b1;
                next = pc + imm_j;
            end
            7'b1100111: begin
                res  = pc + 64'd4;
                wr   = 1'b1;
                next = (x[rs1] + imm_i) & ~64'd1;                       // bit zero dropped
            end
            7'b1100011: if (cond_ref(w[14:12], x[rs1], x[rs2])) next = pc + imm_b;
            7'b0000011: begin
                addr         = x[rs1] + imm_i;
                res          = model_mem[addr[10:3]];
                wr           = 1'b1;
                slot.is_load = 1'b1;
                slot.ld_data = res;
            end
            7'b0100011: begin
                st.addr  = x[rs1] + imm_s;
                st.wdata = x[rs2];
                st.we    = 1'b1;
                exp_stores.push_back(st);
                model_mem[st.addr[10:3]] = st.wdata;
            end
            7'b0010011: begin res = alu_ref(w[14:12], 1'b0, x[rs1], imm_i); wr = 1'b1; end
            7'b0110011: begin res = alu_ref(w[14:12], w[30], x[rs1], x[rs2]); wr = 1'b1; end
            default: ;
        endcase
        if (wr && w[11:7] != 5'd0) x[w[11:7]] = res;
        exp_fetch.push_back(slot);
        if (next != pc + 64'd4) begin       // redirect, pc+4 is fetched then flushed
            slot      = '0;
            slot.addr = pc + 64'd4;
            exp_fetch.push_back(slot);
        end
        pc = next;
    end
endtask

`endif

// File: tb/tb_cpu.sv
// two stage core testbench
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int          PROG_LEN  = 200;
    localparam int          TAIL_LEN  = 33;                  // 32 sd plus self jump
    localparam int          RST_CYC   = 8;
    localparam int          LIMIT_CYC = (PROG_LEN + TAIL_LEN) * 2 + 100;
    localparam logic [31:0] SEED      = 32'h9850_bc5d;
    localparam xlen_t       HALT_PC   = xlen_t'((PROG_LEN + 32) * 4);

    logic             clk_1hz = 1'b0;
    logic             reset_n;
    xlen_t            imem_addr;
    instr_u           imem_data;
    dmem_req_t        dmem_req;
    xlen_t            dmem_rdata;
    logic [`ILEN-1:0] imem [256];
    xlen_t            dmem [256];       // memory seen by the dut
    xlen_t            model_mem [256];  // private copy for the model
    int               fetch_idx;
    int               store_idx;

    `include "isa_model.svh"

    fetch_exp_t exec_slot;         // slot in execute this cycle

    always #2 clk_1hz = ~clk_1hz;

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[10:3]];

    cpu_core dut (
        .clk_1hz    (clk_1hz),
        .reset_n    (reset_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    // instruction formats at their isa bit positions
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};   // sd
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [2:0] alu_funct3();
        case ($urandom % 6)
            0:       return 3'b000;
            1:       return 3'b010;
            2:       return 3'b011;
            3:       return 3'b100;
            4:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [2:0] cond_funct3();
        case ($urandom % 6)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b100;
            3:       return 3'b101;
            4:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    // random body, register dump tail, self jump
    task automatic build_program();
        int          kind;
        int          k;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] off;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = `NOP_INSTR;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = int'($urandom % 10);
            rd   = 5'($urandom);
            rs1  = 5'($urandom);
            rs2  = ($urandom % 2 == 0) ? rs1 : 5'($urandom);     // equal operands now and then
            k    = 2 * (1 + int'($urandom % 3));                 // forward 2, 4 or 6 words
            off  = 12'(($urandom % 256) * 8);                    // inside the data window
            if (kind >= 7 && i + k > PROG_LEN) kind = 2;         // target would leave the body
            case (kind)
                0: imem[8'(i)] = {20'($urandom), rd, 7'b0110111};        // lui
                1: imem[8'(i)] = {20'($urandom), rd, 7'b0010111};        // auipc
                2: imem[8'(i)] = i_type(12'($urandom), rs1, alu_funct3(), rd, 7'b0010011);
                3: imem[8'(i)] = r_type(7'b0000000, rs2, rs1, alu_funct3(), rd);
                4: imem[8'(i)] = r_type(7'b0100000, rs2, rs1, 3'b000, rd);  // sub
                5: imem[8'(i)] = i_type(off, 5'd0, 3'b011, rd, 7'b0000011); // ld
                6: imem[8'(i)] = s_type(off, rs2, 5'd0);
                7: imem[8'(i)] = b_type(13'(k * 4), rs2, rs1, cond_funct3());
                8: imem[8'(i)] = j_type(21'(k * 4), rd);
                default: imem[8'(i)] = i_type(12'((i + k) * 4) | 12'($urandom % 2),
                                              5'd0, 3'b000, rd, 7'b1100111);  // jalr with odd targets too
            endcase
        end
        for (int r = 0; r < 32; r++) begin
            imem[8'(PROG_LEN + r)] = s_type(12'(r * 8), 5'(r), 5'd0);    // x0..x31 dump
        end
        imem[8'(PROG_LEN + 32)] = j_type(21'd0, 5'd0);                   // park here
    endtask

    task automatic word_check(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic store_check(input dmem_req_t got, input dmem_req_t exp);
        if (got !== exp) begin
            $display("ERR dmem_req got addr %h wdata %h exp addr %h wdata %h",
                     got.addr, got.wdata, exp.addr, exp.wdata);
            $display("tests failed");
            $fatal(1, "store mismatch");
        end
    endtask

    initial begin
        reset_n   = 1'b0;
        fetch_idx = 0;
        store_idx = 0;
        exec_slot = '0;
        void'($urandom(SEED));
        build_program();
        for (int a = 0; a < 256; a++) begin
            dmem[8'(a)]      = {$urandom, $urandom};
            model_mem[8'(a)] = dmem[8'(a)];
        end
        interpret_program();
        fork
            // data memory write lands at the edge after the strobe
            forever begin
                @(posedge clk_1hz);
                if (reset_n && dmem_req.we) dmem[dmem_req.addr[10:3]] <= dmem_req.wdata;
            end
            // monitor samples half a cycle after each edge
            forever begin
                @(negedge clk_1hz);
                if (!reset_n || fetch_idx == 0) begin
                    if (dmem_req.we) begin
                        $display("store strobe went high during or right after reset");
                        $display("tests failed");
                        $fatal(1, "reset check");
                    end
                    word_check("imem_addr", imem_addr, `RESET_PC);
                end
                if (reset_n) begin
                    if (exec_slot.is_load) begin
                        word_check("dmem_rdata", dmem_rdata, exec_slot.ld_data);
                    end
                    exec_slot = '0;
                    if (fetch_idx < exp_fetch.size()) begin
                        word_check("imem_addr", imem_addr, exp_fetch[fetch_idx].addr);
                        exec_slot = exp_fetch[fetch_idx];
                        fetch_idx++;
                    end
                    if (dmem_req.we) begin
                        store_check(dmem_req, exp_stores[store_idx]);
                        store_idx++;
                    end
                end
            end
            // watchdog
            begin
                repeat (RST_CYC + LIMIT_CYC) @(posedge clk_1hz);
                $display("only %0d of %0d expected stores appeared before the time limit",
                         store_idx, exp_stores.size());
                $display("tests failed");
                $fatal(1, "timeout");
            end
        join_none
        repeat (RST_CYC) @(posedge clk_1hz);
        reset_n <= 1'b1;
        wait (store_idx == exp_stores.size());      // last register dump store matched
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
+incdir+tb
common/cpu_pkg.sv
execute/decoder.sv
execute/alu.sv
execute/reg_file.sv
execute/execute_unit.sv
fetch/fetch_stage.sv
source/cpu_core.sv
tb/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f filelist.f --top-module tb_cpu -o sim_tb_cpu

# the log decides the result, so a stopped run still gets scanned
./obj_dir/sim_tb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "^all tests passed$" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
